/* source/rvseed_pkg.sv */
package rvseed_pkg;

    // datapath width
    localparam int xlen = 64;
    localparam int shamt_w = $clog2(xlen);  // 6-bit shift amount on the full word

    // credit setup on both sides
    localparam int in_credits  = 2;  // input queue depth
    localparam int out_credits = 2;  // downstream result slots

    // one iteration per multiplier bit
    localparam int mul_steps = 64;

    typedef enum logic [4:0] {
        ALU_ADD  = 5'd0,
        ALU_SUB  = 5'd1,
        ALU_AND  = 5'd2,
        ALU_OR   = 5'd3,
        ALU_XOR  = 5'd4,
        ALU_SLL  = 5'd5,
        ALU_SRL  = 5'd6,
        ALU_SRA  = 5'd7,
        ALU_SLT  = 5'd8,
        ALU_SLTU = 5'd9,
        // branch compares, result goes out on cond
        ALU_BEQ  = 5'd10,
        ALU_BNE  = 5'd11,
        ALU_BLT  = 5'd12,
        ALU_BGE  = 5'd13,
        ALU_BLTU = 5'd14,
        ALU_BGEU = 5'd15,
        ALU_MUL  = 5'd16,  // multi-cycle, handled by the shift-add unit
        ALU_MOV  = 5'd17   // passes src2
    } alu_op_e;

    // result extension, applied after the op
    typedef enum logic [1:0] {
        EXT_NONE = 2'd0,
        EXT_W    = 2'd1,  // sign from bit 31, also 32-bit shifts
        EXT_WU   = 2'd2,  // zero from bit 31
        EXT_H    = 2'd3   // sign from bit 15
    } ext_mode_e;

endpackage

/* source/alu_int.sv */
`timescale 1ns/1ps

module alu_int
    import rvseed_pkg::*;
(
    input  alu_op_e          op,
    input  logic [xlen-1:0]  a,
    input  logic [xlen-1:0]  b,
    input  ext_mode_e        ext,
    output logic [xlen-1:0]  res,
    output logic             cond
);

    logic               word;       // 32-bit shift mode
    logic [shamt_w-1:0] shamt;
    logic [xlen-1:0]    sum;
    logic [xlen-1:0]    diff;
    logic [xlen-1:0]    a_lo_zext;
    logic [xlen-1:0]    a_lo_sext;
    logic               signed_lt;
    logic               unsigned_lt;
    logic               equal;

    assign word  = (ext == EXT_W);
    assign shamt = word ? {1'b0, b[4:0]} : b[shamt_w-1:0];  // word shifts only look at 5 bits

    // low word of a, widened two ways for the word shifts
    assign a_lo_zext = {{(xlen-32){1'b0}}, a[31:0]};
    assign a_lo_sext = {{(xlen-32){a[31]}}, a[31:0]};

    assign sum  = a + b;
    assign diff = a - b;

    assign signed_lt   = ($signed(a) < $signed(b));
    assign unsigned_lt = (a < b);
    assign equal       = (a == b);

    always_comb begin
        res  = diff;  // branches and anything unlisted report a - b
        cond = 1'b0;
        case (op)
            ALU_ADD: res = sum;
            ALU_SUB: res = diff;
            ALU_AND: res = a & b;
            ALU_OR:  res = a | b;
            ALU_XOR: res = a ^ b;
            ALU_SLL: begin
                res = a << shamt;  // upper half is cleaned up by the word extension
            end
            ALU_SRL: begin
                if (word) begin
                    res = a_lo_zext >> shamt;
                end else begin
                    res = a >> shamt;
                end
            end
            ALU_SRA: begin
                // word form shifts in bit 31
                if (word) begin
                    res = $signed(a_lo_sext) >>> shamt;
                end else begin
                    res = $signed(a) >>> shamt;
                end
            end
            ALU_SLT:  res = {{(xlen-1){1'b0}}, signed_lt};
            ALU_SLTU: res = {{(xlen-1){1'b0}}, unsigned_lt};
            ALU_BEQ:  cond = equal;
            ALU_BNE:  cond = !equal;
            ALU_BLT:  cond = signed_lt;
            ALU_BGE:  cond = !signed_lt;
            ALU_BLTU: cond = unsigned_lt;
            ALU_BGEU: cond = !unsigned_lt;
            ALU_MOV:  res = b;
            default: begin
                // ALU_MUL, product comes from the multiplier
                res  = diff;
                cond = 1'b0;
            end
        endcase
    end

endmodule

/* source/mul_shift_add.sv */
`timescale 1ns/1ps

module mul_shift_add
    import rvseed_pkg::*;
(
    input  logic             clk,
    input  logic             rst_n,
    input  logic             start,
    input  logic [xlen-1:0]  a,
    input  logic [xlen-1:0]  b,
    output logic             busy,
    output logic             done,
    output logic [xlen-1:0]  product
);

    localparam int step_w = $clog2(mul_steps);

    logic [2*xlen-1:0] acc;
    logic [2*xlen-1:0] mcand;    // sign-extended a, shifted left each step
    logic [xlen-1:0]   mplier;   // b, shifted right each step
    logic [step_w-1:0] step;
    logic              last_step;
    logic [2*xlen-1:0] addend;

    assign last_step = (step == step_w'(mul_steps - 1));

    // top multiplier bit has negative weight in two's complement,
    // so the final step subtracts
    always_comb begin
        if (!mplier[0]) begin
            addend = '0;
        end else if (last_step) begin
            addend = -mcand;
        end else begin
            addend = mcand;
        end
    end

    assign product = acc[xlen-1:0];  // low half only

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            busy <= 1'b0;
            done <= 1'b0;
            step <= '0;
        end else begin
            done <= 1'b0;
            if (start) begin
                busy <= 1'b1;
                step <= '0;
            end else if (busy) begin
                step <= step + 1'b1;
                if (last_step) begin
                    busy <= 1'b0;
                    done <= 1'b1;  // one cycle, product valid with it
                end
            end
        end
    end

    // datapath
    always_ff @(posedge clk) begin
        if (start) begin
            acc    <= '0;
            mcand  <= {{xlen{a[xlen-1]}}, a};
            mplier <= b;
        end else if (busy) begin
            acc    <= acc + addend;
            mcand  <= mcand << 1;
            mplier <= mplier >> 1;
        end
    end

endmodule

/* source/exu_ctrl.sv */
`timescale 1ns/1ps

module exu_ctrl
    import rvseed_pkg::*;
(
    input  logic             clk,
    input  logic             rst_n,
    input  logic             op_valid,
    input  alu_op_e          op,
    input  logic [xlen-1:0]  src1,
    input  logic [xlen-1:0]  src2,
    input  ext_mode_e        ext,
    input  logic             res_credit,
    input  logic [xlen-1:0]  alu_res,
    input  logic             alu_cond,
    input  logic             mul_busy,
    input  logic             mul_done,
    input  logic [xlen-1:0]  mul_product,
    output logic             in_credit,
    output logic             res_valid,
    output logic [xlen-1:0]  res,
    output logic             res_cond,
    output alu_op_e          alu_op,
    output logic [xlen-1:0]  alu_a,
    output logic [xlen-1:0]  alu_b,
    output ext_mode_e        alu_ext,
    output logic             mul_start,
    output logic [xlen-1:0]  mul_a,
    output logic [xlen-1:0]  mul_b
);

    localparam int ptr_w = $clog2(in_credits);
    localparam int qcnt_w = $clog2(in_credits + 1);
    localparam int ocnt_w = $clog2(out_credits + 1);

    typedef enum logic {
        EXU_IDLE,
        EXU_MUL_WAIT
    } exu_state_e;

    // input queue, no reset on the entries
    alu_op_e         q_op  [in_credits];
    logic [xlen-1:0] q_a   [in_credits];
    logic [xlen-1:0] q_b   [in_credits];
    ext_mode_e       q_ext [in_credits];

    logic [ptr_w-1:0]  wr_ptr;
    logic [ptr_w-1:0]  rd_ptr;
    logic [qcnt_w-1:0] q_count;
    logic [ocnt_w-1:0] out_cnt;

    exu_state_e state;

    logic            head_valid;
    logic            has_credit;
    logic            alu_take;
    logic            mul_take;
    logic            pop;
    logic [xlen-1:0] sel_res;
    logic            sel_cond;

    function automatic logic [xlen-1:0] extend(input logic [xlen-1:0] v, input ext_mode_e m);
        case (m)
            EXT_W:   return {{(xlen-32){v[31]}}, v[31:0]};
            EXT_WU:  return {{(xlen-32){1'b0}}, v[31:0]};
            EXT_H:   return {{(xlen-16){v[15]}}, v[15:0]};
            default: return v;
        endcase
    endfunction

    assign head_valid = (q_count != '0);
    assign has_credit = (out_cnt != '0);

    // head of queue feeds both units
    assign alu_op  = q_op[rd_ptr];
    assign alu_a   = q_a[rd_ptr];
    assign alu_b   = q_b[rd_ptr];
    assign alu_ext = q_ext[rd_ptr];
    assign mul_a   = q_a[rd_ptr];
    assign mul_b   = q_b[rd_ptr];

    // multiply only starts with a slot reserved, so done never stalls
    assign mul_start = head_valid && (alu_op == ALU_MUL) && (state == EXU_IDLE)
                       && has_credit && !mul_busy;
    assign alu_take  = head_valid && (alu_op != ALU_MUL) && (state == EXU_IDLE) && has_credit;
    assign mul_take  = (state == EXU_MUL_WAIT) && mul_done;
    assign pop       = alu_take || mul_take;
    assign in_credit = pop;  // one credit back per popped entry

    assign sel_res  = (state == EXU_MUL_WAIT) ? mul_product : alu_res;
    assign sel_cond = (state == EXU_MUL_WAIT) ? 1'b0 : alu_cond;

    always_ff @(posedge clk) begin
        if (op_valid) begin
            q_op[wr_ptr]  <= op;
            q_a[wr_ptr]   <= src1;
            q_b[wr_ptr]   <= src2;
            q_ext[wr_ptr] <= ext;
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            wr_ptr  <= '0;
            rd_ptr  <= '0;
            q_count <= '0;
            out_cnt <= ocnt_w'(out_credits);
            state   <= EXU_IDLE;
        end else begin
            if (op_valid) wr_ptr <= wr_ptr + 1'b1;
            if (pop)      rd_ptr <= rd_ptr + 1'b1;
            case ({op_valid, pop})
                2'b10:   q_count <= q_count + 1'b1;
                2'b01:   q_count <= q_count - 1'b1;
                default: q_count <= q_count;
            endcase
            // a slot is spent when the result is loaded
            case ({pop, res_credit})
                2'b10:   out_cnt <= out_cnt - 1'b1;
                2'b01:   out_cnt <= out_cnt + 1'b1;
                default: out_cnt <= out_cnt;
            endcase
            case (state)
                EXU_IDLE:     if (mul_start) state <= EXU_MUL_WAIT;
                EXU_MUL_WAIT: if (mul_done) state <= EXU_IDLE;
                default:      state <= EXU_IDLE;
            endcase
        end
    end

    // output register
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            res_valid <= 1'b0;
        end else begin
            res_valid <= pop;
        end
    end

    always_ff @(posedge clk) begin
        if (pop) begin
            res      <= extend(sel_res, alu_ext);
            res_cond <= sel_cond;
        end
    end

endmodule

/* source/rvseed_exu.sv */
`timescale 1ns/1ps

module rvseed_exu
    import rvseed_pkg::*;
(
    input  logic             clk,
    input  logic             rst_n,
    input  logic             op_valid,
    input  alu_op_e          op,
    input  logic [xlen-1:0]  src1,
    input  logic [xlen-1:0]  src2,
    input  ext_mode_e        ext,
    output logic             in_credit,
    output logic             res_valid,
    output logic [xlen-1:0]  res,
    output logic             res_cond,
    input  logic             res_credit
);

    // controller to alu
    alu_op_e         alu_op;
    logic [xlen-1:0] alu_a;
    logic [xlen-1:0] alu_b;
    ext_mode_e       alu_ext;
    logic [xlen-1:0] alu_res;
    logic            alu_cond;

    // controller to multiplier
    logic            mul_start;
    logic            mul_busy;
    logic            mul_done;
    logic [xlen-1:0] mul_a;
    logic [xlen-1:0] mul_b;
    logic [xlen-1:0] mul_product;

    exu_ctrl u_exu_ctrl (
        .clk         (clk),
        .rst_n       (rst_n),
        .op_valid    (op_valid),
        .op          (op),
        .src1        (src1),
        .src2        (src2),
        .ext         (ext),
        .res_credit  (res_credit),
        .alu_res     (alu_res),
        .alu_cond    (alu_cond),
        .mul_busy    (mul_busy),
        .mul_done    (mul_done),
        .mul_product (mul_product),
        .in_credit   (in_credit),
        .res_valid   (res_valid),
        .res         (res),
        .res_cond    (res_cond),
        .alu_op      (alu_op),
        .alu_a       (alu_a),
        .alu_b       (alu_b),
        .alu_ext     (alu_ext),
        .mul_start   (mul_start),
        .mul_a       (mul_a),
        .mul_b       (mul_b)
    );

    alu_int u_alu_int (
        .op   (alu_op),
        .a    (alu_a),
        .b    (alu_b),
        .ext  (alu_ext),
        .res  (alu_res),
        .cond (alu_cond)
    );

    mul_shift_add u_mul_shift_add (
        .clk     (clk),
        .rst_n   (rst_n),
        .start   (mul_start),
        .a       (mul_a),
        .b       (mul_b),
        .busy    (mul_busy),
        .done    (mul_done),
        .product (mul_product)
    );

endmodule

/* tb/exu_checker.sv */
`timescale 1ns/1ps

module exu_checker
    import rvseed_pkg::*;
(
    input  logic             clk,
    input  logic             rst_n,
    input  logic             op_valid,
    input  logic [xlen-1:0]  exp_res,
    input  logic             exp_cond,
    input  logic             res_valid,
    input  logic [xlen-1:0]  res,
    input  logic             res_cond,
    output int               pass_cnt,
    output int               fail_cnt,
    output int               seen_cnt
);

    // expected results in issue order
    logic [xlen-1:0] res_q  [$];
    logic            cond_q [$];
    int              idx_q  [$];
    int              issued;

    initial begin
        pass_cnt = 0;
        fail_cnt = 0;
        seen_cnt = 0;
        issued   = 0;
    end

    always @(posedge clk) begin
        logic [xlen-1:0] want_res;
        logic            want_cond;
        int              idx;
        if (rst_n) begin
            // retire before push, an op never returns in its own issue cycle
            if (res_valid) begin
                if (res_q.size() == 0) begin
                    $display("a result arrived at %0t with no test outstanding", $time);
                    fail_cnt++;
                end else begin
                    want_res  = res_q.pop_front();
                    want_cond = cond_q.pop_front();
                    idx       = idx_q.pop_front();
                    seen_cnt++;
                    if (res === want_res && res_cond === want_cond) begin
                        pass_cnt++;
                        $display("test %0d ok: res %h cond %b", idx, res, res_cond);
                    end else begin
                        fail_cnt++;
                        $display("** Error at %0t: entry %0d res %h cond %b, expected %h cond %b",
                                 $time, idx, res, res_cond, want_res, want_cond);
                    end
                end
            end
            if (op_valid) begin
                res_q.push_back(exp_res);
                cond_q.push_back(exp_cond);
                idx_q.push_back(issued);
                issued++;
            end
        end
    end

endmodule

/* tb/exu_assertions.sv */
`timescale 1ns/1ps

module exu_assertions
    import rvseed_pkg::*;
(
    input  logic clk,
    input  logic rst_n,
    input  logic op_valid,
    input  logic in_credit,
    input  logic res_valid,
    input  logic res_credit,
    input  logic mul_start,
    input  logic mul_done
);

    int up_credits;  // what the sender should hold
    int dn_credits;  // free result slots as seen on the ports
    int mul_age;     // cycles since mul_start, 0 when idle

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            up_credits <= in_credits;
            dn_credits <= out_credits;
            mul_age    <= 0;
        end else begin
            up_credits <= up_credits - int'(op_valid) + int'(in_credit);
            dn_credits <= dn_credits - int'(res_valid) + int'(res_credit);
            if (mul_start) begin
                mul_age <= 1;
            end else if (mul_done) begin
                mul_age <= 0;
            end else if (mul_age != 0) begin
                mul_age <= mul_age + 1;
            end
        end
    end

    upstream_credit: assert property (@(posedge clk) disable iff (!rst_n)
        op_valid |-> up_credits > 0)
        else $error("op_valid without upstream credit");

    // never more credits back than entries taken
    credit_return: assert property (@(posedge clk) disable iff (!rst_n)
        up_credits <= in_credits)
        else $error("in_credit returned more credits than were spent");

    downstream_credit: assert property (@(posedge clk) disable iff (!rst_n)
        res_valid |-> dn_credits > 0)
        else $error("res_valid sent with no free result slot");

    mul_latency: assert property (@(posedge clk) disable iff (!rst_n)
        mul_done |-> mul_age == mul_steps + 1)
        else $error("mul_done at wrong distance from mul_start");

endmodule

/* tb/rvseed_exu_tb.sv */
`timescale 1ns/1ps

module rvseed_exu_tb
    import rvseed_pkg::*;
;

    logic            clk;
    logic            rst_n;
    logic            op_valid;
    alu_op_e         op;
    logic [xlen-1:0] src1;
    logic [xlen-1:0] src2;
    ext_mode_e       ext;
    logic            in_credit;
    logic            res_valid;
    logic [xlen-1:0] res;
    logic            res_cond;
    logic            res_credit;
    logic [xlen-1:0] exp_res;
    logic            exp_cond;
    int              pass_cnt;
    int              fail_cnt;
    int              seen_cnt;

    // stimulus table
    alu_op_e         t_op   [$];
    logic [xlen-1:0] t_a    [$];
    logic [xlen-1:0] t_b    [$];
    ext_mode_e       t_ext  [$];
    logic [xlen-1:0] t_res  [$];
    logic            t_cond [$];

    int          credits;
    int          cycle;
    int          limit;
    int          due_q [$];  // cycles when a downstream slot frees
    logic [31:0] lfsr_state;

    rvseed_exu u_rvseed_exu (
        .clk        (clk),
        .rst_n      (rst_n),
        .op_valid   (op_valid),
        .op         (op),
        .src1       (src1),
        .src2       (src2),
        .ext        (ext),
        .in_credit  (in_credit),
        .res_valid  (res_valid),
        .res        (res),
        .res_cond   (res_cond),
        .res_credit (res_credit)
    );

    exu_checker u_exu_checker (
        .clk       (clk),
        .rst_n     (rst_n),
        .op_valid  (op_valid),
        .exp_res   (exp_res),
        .exp_cond  (exp_cond),
        .res_valid (res_valid),
        .res       (res),
        .res_cond  (res_cond),
        .pass_cnt  (pass_cnt),
        .fail_cnt  (fail_cnt),
        .seen_cnt  (seen_cnt)
    );

    bind exu_ctrl exu_assertions u_exu_assertions (
        .clk        (clk),
        .rst_n      (rst_n),
        .op_valid   (op_valid),
        .in_credit  (in_credit),
        .res_valid  (res_valid),
        .res_credit (res_credit),
        .mul_start  (mul_start),
        .mul_done   (mul_done)
    );

    // taps 32 22 2 1
    function automatic logic [31:0] lfsr_next(input logic [31:0] s);
        logic fb;
        fb = s[31] ^ s[21] ^ s[1] ^ s[0];
        return {s[30:0], fb};
    endfunction

    task automatic add_entry(input alu_op_e o, input logic [xlen-1:0] a,
                             input logic [xlen-1:0] b, input ext_mode_e e,
                             input logic [xlen-1:0] r, input logic c);
        t_op.push_back(o);
        t_a.push_back(a);
        t_b.push_back(b);
        t_ext.push_back(e);
        t_res.push_back(r);
        t_cond.push_back(c);
    endtask

    task automatic build_table();
        logic [xlen-1:0] neg1;
        neg1 = 64'h8000_0000_0000_0001;  // differs from 1 only in the top bit
        add_entry(ALU_ADD, 64'd5, 64'd7, EXT_NONE, 64'd12, 1'b0);
        add_entry(ALU_ADD, '1, 64'd1, EXT_NONE, 64'd0, 1'b0);
        add_entry(ALU_ADD, 64'h7fff_ffff, 64'd1, EXT_W, 64'hffff_ffff_8000_0000, 1'b0);
        add_entry(ALU_SUB, 64'd3, 64'd5, EXT_NONE, 64'hffff_ffff_ffff_fffe, 1'b0);
        add_entry(ALU_SUB, 64'h8000_0000_0000_0000, 64'd1, EXT_NONE,
                  64'h7fff_ffff_ffff_ffff, 1'b0);
        add_entry(ALU_AND, 64'hf0f0_f0f0_f0f0_f0f0, 64'hff00_ff00_ff00_ff00, EXT_NONE,
                  64'hf000_f000_f000_f000, 1'b0);
        add_entry(ALU_OR, 64'h00ff_00ff_00ff_00ff, 64'h0f0f_0f0f_0f0f_0f0f, EXT_NONE,
                  64'h0fff_0fff_0fff_0fff, 1'b0);
        add_entry(ALU_XOR, 64'haaaa_aaaa_aaaa_aaaa, 64'hffff_ffff_0000_0000, EXT_NONE,
                  64'h5555_5555_aaaa_aaaa, 1'b0);
        add_entry(ALU_SLL, 64'd1, 64'd63, EXT_NONE, 64'h8000_0000_0000_0000, 1'b0);
        add_entry(ALU_SRL, 64'h8000_0000_0000_0000, 64'd4, EXT_NONE,
                  64'h0800_0000_0000_0000, 1'b0);
        add_entry(ALU_SRA, 64'h8000_0000_0000_0000, 64'd4, EXT_NONE,
                  64'hf800_0000_0000_0000, 1'b0);
        // word shifts, amount 0x21 acts as 1
        add_entry(ALU_SLL, 64'h4000_0000, 64'h21, EXT_W, 64'hffff_ffff_8000_0000, 1'b0);
        add_entry(ALU_SRL, 64'hffff_ffff_8000_0000, 64'd4, EXT_W, 64'h0800_0000, 1'b0);
        add_entry(ALU_SRA, 64'h8000_0000, 64'd4, EXT_W, 64'hffff_ffff_f800_0000, 1'b0);
        add_entry(ALU_SLT, neg1, 64'd1, EXT_NONE, 64'd1, 1'b0);
        add_entry(ALU_SLTU, neg1, 64'd1, EXT_NONE, 64'd0, 1'b0);
        add_entry(ALU_BEQ, neg1, 64'd1, EXT_NONE, 64'h8000_0000_0000_0000, 1'b0);
        add_entry(ALU_BNE, neg1, 64'd1, EXT_NONE, 64'h8000_0000_0000_0000, 1'b1);
        add_entry(ALU_BLT, neg1, 64'd1, EXT_NONE, 64'h8000_0000_0000_0000, 1'b1);
        add_entry(ALU_BGE, neg1, 64'd1, EXT_NONE, 64'h8000_0000_0000_0000, 1'b0);
        add_entry(ALU_BLTU, neg1, 64'd1, EXT_NONE, 64'h8000_0000_0000_0000, 1'b0);
        add_entry(ALU_BGEU, neg1, 64'd1, EXT_NONE, 64'h8000_0000_0000_0000, 1'b1);
        add_entry(ALU_BEQ, 64'h1234, 64'h1234, EXT_NONE, 64'd0, 1'b1);
        add_entry(ALU_MUL, 64'd7, 64'd6, EXT_NONE, 64'd42, 1'b0);
        add_entry(ALU_MUL, 64'hffff_ffff_ffff_fffd, 64'd5, EXT_NONE,
                  64'hffff_ffff_ffff_fff1, 1'b0);
        add_entry(ALU_ADD, 64'd1, 64'd1, EXT_NONE, 64'd2, 1'b0);  // queued behind the multiply
        add_entry(ALU_MUL, 64'hffff_ffff_ffff_fffc, 64'hffff_ffff_ffff_fffa, EXT_NONE,
                  64'd24, 1'b0);
        add_entry(ALU_MUL, 64'h1_0000_0000, 64'h1_0000_0001, EXT_NONE,
                  64'h1_0000_0000, 1'b0);
        add_entry(ALU_MOV, 64'd0, 64'h8001, EXT_H, 64'hffff_ffff_ffff_8001, 1'b0);
        add_entry(ALU_MOV, 64'd0, 64'hffff_ffff_8000_0001, EXT_WU, 64'h8000_0001, 1'b0);
        add_entry(ALU_MOV, 64'd0, 64'h0123_4567_89ab_cdef, EXT_NONE,
                  64'h0123_4567_89ab_cdef, 1'b0);
    endtask

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    // upstream credits, cycle count, downstream slot model and timeout
    always @(posedge clk or negedge rst_n) begin
        int delay;
        if (!rst_n) begin
            credits = in_credits;
            cycle   = 0;
        end else begin
            credits = credits - int'(op_valid) + int'(in_credit);
            cycle   = cycle + 1;
            if (res_valid) begin
                delay = 0;
                for (int k = 0; k < 4; k++) begin
                    lfsr_state = lfsr_next(lfsr_state);
                    delay = delay * 2 + int'(lfsr_state[0]);
                end
                due_q.push_back(cycle + 1 + delay);
            end
            if (limit > 0 && cycle >= limit) begin
                $display("timeout: results stopped arriving after %0d cycles", cycle);
                $display("tests failed");
                $finish;
            end
        end
    end

    always @(negedge clk) begin
        res_credit = 1'b0;
        if (due_q.size() > 0 && due_q[0] <= cycle) begin
            res_credit = 1'b1;  // one slot back per cycle at most
            void'(due_q.pop_front());
        end
    end

    initial begin
        int i;
        rst_n      = 1'b0;
        op_valid   = 1'b0;
        op         = ALU_ADD;
        src1       = '0;
        src2       = '0;
        ext        = EXT_NONE;
        res_credit = 1'b0;
        exp_res    = '0;
        exp_cond   = 1'b0;
        lfsr_state = 32'hb261_1d77;
        limit      = 0;
        credits    = in_credits;
        cycle      = 0;
        build_table();
        limit = t_op.size() * (mul_steps + 10);
        repeat (2) @(posedge clk);
        @(negedge clk);
        rst_n = 1'b1;
        i = 0;
        while (i < t_op.size()) begin
            @(negedge clk);
            if (credits > 0) begin
                op_valid = 1'b1;
                op       = t_op[i];
                src1     = t_a[i];
                src2     = t_b[i];
                ext      = t_ext[i];
                exp_res  = t_res[i];
                exp_cond = t_cond[i];
                i++;
            end else begin
                op_valid = 1'b0;  // stalled on upstream credit
            end
        end
        @(negedge clk);
        op_valid = 1'b0;
        wait (seen_cnt == t_op.size());
        repeat (8) @(posedge clk);  // catch stray extra results
        $display("%0d passed, %0d failed, %0d of %0d results seen",
                 pass_cnt, fail_cnt, seen_cnt, t_op.size());
        if (fail_cnt == 0 && seen_cnt == t_op.size()) begin
            $display("all tests passed");
        end else begin
            $display("tests failed");
        end
        $finish;
    end

endmodule

/* rvseed_exu.f */
source/rvseed_pkg.sv
source/alu_int.sv
source/mul_shift_add.sv
source/exu_ctrl.sv
source/rvseed_exu.sv
tb/exu_checker.sv
tb/exu_assertions.sv
tb/rvseed_exu_tb.sv

/* Makefile */
VERILATOR ?= verilator
TOP       ?= rvseed_exu_tb
FILELIST  ?= rvseed_exu.f
BUILD_DIR ?= obj_dir
VFLAGS    ?= --binary --timing --assert

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)
	@out="$$(./$(BUILD_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx 'all tests passed'

clean:
	rm -rf $(BUILD_DIR)
